//--- logic/expipe_cfg.svh
/* Global sizes for the execution back end
   EXPIPE_RS_DEPTH must be a power of two, at least 2 */
`ifndef EXPIPE_CFG_SVH_
`define EXPIPE_CFG_SVH_

// ------------------------------
// Datapath
// ------------------------------
// Operand and result width
`define EXPIPE_XLEN 32

// ------------------------------
// Tags and queues
// ------------------------------
// ROB tag width, 16 in-flight instructions
`define EXPIPE_ROB_IDX_LEN 4

// Entries per reservation station
`define EXPIPE_RS_DEPTH 4

`endif

//--- logic/expipe_pkg.sv
/* Types shared by the stations, the CDB arbiter and the top level
   Widths follow expipe_cfg.svh */
`include "expipe_cfg.svh"

package expipe_pkg;

  // ------------------------------
  // Tags and exception codes
  // ------------------------------
  // Reorder buffer entry index
  typedef logic [`EXPIPE_ROB_IDX_LEN-1:0] rob_idx_t;

  // Subset of the trap causes
  // E_UNKNOWN marks results without a meaningful cause
  typedef enum logic [3:0] {
    E_INSTR_ADDR_MISALIGNED = 4'h0,
    E_INSTR_ACCESS_FAULT    = 4'h1,
    E_ILLEGAL_INSTRUCTION   = 4'h2,
    E_BREAKPOINT            = 4'h3,
    E_LD_ADDR_MISALIGNED    = 4'h4,
    E_ST_ADDR_MISALIGNED    = 4'h6,
    E_UNKNOWN               = 4'hf
  } except_code_t;

  // ------------------------------
  // Bus payloads
  // ------------------------------
  // One result on the common data bus
  typedef struct packed {
    rob_idx_t                rob_idx;
    logic [`EXPIPE_XLEN-1:0] res_value;
    logic                    except_raised;
    except_code_t            except_code;
  } cdb_data_t;

  // Issued instruction, single operand
  typedef struct packed {
    logic                    rs1_ready;  // rs1_value already valid
    rob_idx_t                rs1_idx;    // Producer tag while waiting
    logic [`EXPIPE_XLEN-1:0] rs1_value;
    rob_idx_t                dest_idx;   // Own ROB tag
  } rs_issue_t;

endpackage

//--- logic/modn_counter.sv
/* Counts 0..N-1 and wraps; N of at least 2
   Clear beats enable */
`timescale 1ns/1ps

module modn_counter #(
  parameter int unsigned N = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 en_i,
  input  logic                 clr_i,
  output logic [$clog2(N)-1:0] count_o,
  output logic                 tc_o
);

  localparam int unsigned CntW = $clog2(N);
  localparam logic [CntW-1:0] LastCnt = CntW'(N - 1);

  logic [CntW-1:0] count_q;

  // Last value before wrapping
  assign tc_o    = (count_q == LastCnt);
  assign count_o = count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (clr_i) begin
      count_q <= '0;
    end else if (en_i) begin
      // Explicit wrap, also correct for N not a power of two
      count_q <= tc_o ? '0 : count_q + 1'b1;
    end
  end

endmodule

//--- logic/op_only_rs.sv
/* In-order operand-only station, results leave in issue order
   Results never raise an exception; DEPTH must be a power of two */
`timescale 1ns/1ps
`include "expipe_cfg.svh"

module op_only_rs
  import expipe_pkg::*;
#(
  parameter int unsigned DEPTH = `EXPIPE_RS_DEPTH
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  // Issue side
  input  logic      issue_valid_i,
  input  rs_issue_t issue_data_i,
  output logic      issue_ready_o,
  // Broadcast from the CDB
  input  logic      bcast_valid_i,
  input  cdb_data_t bcast_data_i,
  // Request towards the arbiter
  input  logic      cdb_ready_i,
  output logic      cdb_valid_o,
  output cdb_data_t cdb_data_o
);

  localparam int unsigned IdxW = $clog2(DEPTH);

  // Payload part of an entry
  typedef struct packed {
    rob_idx_t                rs1_idx;
    logic [`EXPIPE_XLEN-1:0] rs1_value;
    rob_idx_t                dest_idx;
  } rs_payload_t;

  // Entry status, one bit per slot
  logic [DEPTH-1:0] valid_q;
  logic [DEPTH-1:0] ready_q;
  rs_payload_t      payload_q [DEPTH];

  logic [IdxW-1:0]  head_idx;
  logic [IdxW-1:0]  tail_idx;
  logic             push;
  logic             pop;

  // Wakeup signals
  logic             bcast_ok;
  logic [DEPTH-1:0] wake;
  logic             issue_wake;
  logic             issue_value_fwd;

  // ------------------------------
  // Wakeup
  // ------------------------------
  // Excepting results never satisfy an operand
  assign bcast_ok = bcast_valid_i & ~bcast_data_i.except_raised;

  // Tag match on every waiting entry in parallel
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      wake[i] = bcast_ok & valid_q[i] & ~ready_q[i]
              & (payload_q[i].rs1_idx == bcast_data_i.rob_idx);
    end
  end

  // Producer broadcast in the same cycle as the issue
  // Without this the entry would wait for a tag already gone
  assign issue_wake      = bcast_ok & (issue_data_i.rs1_idx == bcast_data_i.rob_idx);
  assign issue_value_fwd = issue_wake & ~issue_data_i.rs1_ready;

  // ------------------------------
  // Handshakes
  // ------------------------------
  // Free tail slot accepts an issue
  assign issue_ready_o = ~valid_q[tail_idx];
  assign push          = issue_valid_i & issue_ready_o;

  // Head requests once its operand is in
  assign cdb_valid_o = valid_q[head_idx] & ready_q[head_idx];
  // Arbiter ready is already the grant
  assign pop         = cdb_valid_o & cdb_ready_i;

  // ------------------------------
  // Entry status
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      ready_q <= '0;
    end else if (flush_i) begin
      // Flush drops everything, pointers clear alongside
      valid_q <= '0;
      ready_q <= '0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (wake[i]) begin
          ready_q[i] <= 1'b1;
        end
      end
      if (push) begin
        valid_q[tail_idx] <= 1'b1;
        ready_q[tail_idx] <= issue_data_i.rs1_ready | issue_wake;
      end
      // Head and tail never collide here: a valid head blocks the tail
      if (pop) begin
        valid_q[head_idx] <= 1'b0;
      end
    end
  end

  // ------------------------------
  // Entry payload
  // ------------------------------
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (wake[i]) begin
        payload_q[i].rs1_value <= bcast_data_i.res_value;
      end
    end
    if (push) begin
      payload_q[tail_idx].rs1_idx   <= issue_data_i.rs1_idx;
      payload_q[tail_idx].dest_idx  <= issue_data_i.dest_idx;
      payload_q[tail_idx].rs1_value <= issue_value_fwd ? bcast_data_i.res_value
                                                       : issue_data_i.rs1_value;
    end
  end

  // ------------------------------
  // Pointers
  // ------------------------------
  modn_counter #(
    .N(DEPTH)
  ) head_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (pop),
    .clr_i  (flush_i),
    .count_o(head_idx),
    .tc_o   ()
  );

  // Wrap flags unused, full and empty come from the entry valid bits
  modn_counter #(
    .N(DEPTH)
  ) tail_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (push),
    .clr_i  (flush_i),
    .count_o(tail_idx),
    .tc_o   ()
  );

  // ------------------------------
  // Result
  // ------------------------------
  // Operand moves straight to the result
  assign cdb_data_o.rob_idx       = payload_q[head_idx].dest_idx;
  assign cdb_data_o.res_value     = payload_q[head_idx].rs1_value;
  assign cdb_data_o.except_raised = 1'b0;
  assign cdb_data_o.except_code   = E_UNKNOWN;

endmodule

//--- logic/cdb_arbiter.sv
/* Round-robin CDB arbiter for exactly three requesters
   Requesters must hold valid and data until granted */
`timescale 1ns/1ps

module cdb_arbiter
  import expipe_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [2:0] req_valid_i,
  input  cdb_data_t  req_data_i [3],
  output logic [2:0] req_ready_o,
  input  logic       cdb_ready_i,
  output logic       cdb_valid_o,
  output cdb_data_t  cdb_data_o
);

  localparam int unsigned NReq = 3;

  // Rotating priority, index of the favoured requester
  logic [1:0] prio_q;
  // Grant held over a stalled cycle
  logic       lock_q;
  logic [1:0] lock_idx_q;
  logic [1:0] winner;
  logic       xfer;

  // ------------------------------
  // Grant
  // ------------------------------
  always_comb begin : grant_search
    logic [1:0] cand;
    logic       found;
    winner = prio_q;
    found  = 1'b0;
    // First valid at or after the pointer
    for (int i = 0; i < NReq; i++) begin
      cand = 2'((int'(prio_q) + i) % NReq);
      if (!found && req_valid_i[cand]) begin
        winner = cand;
        found  = 1'b1;
      end
    end
    // Stalled winner keeps the bus so its data stays put
    if (lock_q && req_valid_i[lock_idx_q]) begin
      winner = lock_idx_q;
    end
  end

  assign cdb_valid_o = |req_valid_i;
  assign cdb_data_o  = req_data_i[winner];
  assign xfer        = cdb_valid_o & cdb_ready_i;

  // Ready goes to the winner only
  always_comb begin
    req_ready_o         = '0;
    req_ready_o[winner] = cdb_ready_i & req_valid_i[winner];
  end

  // ------------------------------
  // Pointer and lock
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= cdb_valid_o & ~cdb_ready_i;
      lock_idx_q <= winner;
      // Move one past the winner
      if (xfer) begin
        prio_q <= (winner == 2'(NReq - 1)) ? '0 : winner + 1'b1;
      end
    end
  end

endmodule

//--- logic/expipe_top.sv
/* Two operand-only stations and an external port sharing one CDB
   The granted result is also the broadcast seen by both stations */
`timescale 1ns/1ps
`include "expipe_cfg.svh"

module expipe_top
  import expipe_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  // CSR station issue
  input  logic      csr_issue_valid_i,
  input  rs_issue_t csr_issue_i,
  output logic      csr_issue_ready_o,
  // Link-address station issue
  input  logic      link_issue_valid_i,
  input  rs_issue_t link_issue_i,
  output logic      link_issue_ready_o,
  // Other execution units
  input  logic      ext_valid_i,
  input  cdb_data_t ext_data_i,
  output logic      ext_ready_o,
  // Towards the ROB
  input  logic      cdb_ready_i,
  output logic      cdb_valid_o,
  output cdb_data_t cdb_data_o
);

  // Requester order: 0 external, 1 CSR, 2 link
  logic [2:0] req_valid;
  logic [2:0] req_ready;
  cdb_data_t  req_data [3];

  logic       csr_valid;
  cdb_data_t  csr_data;
  logic       link_valid;
  cdb_data_t  link_data;

  // Strobe only on a completed transfer
  logic       bcast_valid;

  assign bcast_valid = cdb_valid_o & cdb_ready_i;

  // ------------------------------
  // Requester packing
  // ------------------------------
  assign req_valid   = {link_valid, csr_valid, ext_valid_i};
  assign req_data    = '{ext_data_i, csr_data, link_data};
  assign ext_ready_o = req_ready[0];

  // ------------------------------
  // Stations
  // ------------------------------
  op_only_rs #(
    .DEPTH(`EXPIPE_RS_DEPTH)
  ) csr_rs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .issue_valid_i(csr_issue_valid_i),
    .issue_data_i (csr_issue_i),
    .issue_ready_o(csr_issue_ready_o),
    .bcast_valid_i(bcast_valid),
    .bcast_data_i (cdb_data_o),
    .cdb_ready_i  (req_ready[1]),
    .cdb_valid_o  (csr_valid),
    .cdb_data_o   (csr_data)
  );

  op_only_rs #(
    .DEPTH(`EXPIPE_RS_DEPTH)
  ) link_rs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .issue_valid_i(link_issue_valid_i),
    .issue_data_i (link_issue_i),
    .issue_ready_o(link_issue_ready_o),
    .bcast_valid_i(bcast_valid),
    .bcast_data_i (cdb_data_o),
    .cdb_ready_i  (req_ready[2]),
    .cdb_valid_o  (link_valid),
    .cdb_data_o   (link_data)
  );

  // ------------------------------
  // Arbiter
  // ------------------------------
  cdb_arbiter cdb_arb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_valid_i(req_valid),
    .req_data_i (req_data),
    .req_ready_o(req_ready),
    .cdb_ready_i(cdb_ready_i),
    .cdb_valid_o(cdb_valid_o),
    .cdb_data_o (cdb_data_o)
  );

endmodule

//--- tests/expipe_checker.sv
/* CDB protocol assertions bound into expipe_top
   Hold check is skipped in a flush cycle */
`timescale 1ns/1ps

module expipe_checker
  import expipe_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input logic       flush_i,
  input logic [2:0] req_valid_i,
  input logic [2:0] req_ready_i,
  input logic       cdb_ready_i,
  input logic       cdb_valid_i,
  input cdb_data_t  cdb_data_i
);

  // Stalled result keeps valid and data until the ROB takes it
  cdb_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cdb_valid_i && !cdb_ready_i && !flush_i |=> cdb_valid_i && $stable(cdb_data_i))
    else $error("CDB result changed while stalled");

  // One grant at a time, only to a requesting source and only on a transfer
  grant_unique_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(req_ready_i) && ((req_ready_i & ~req_valid_i) == 3'b000)
    && ((req_ready_i != 3'b000) == (cdb_valid_i && cdb_ready_i)))
    else $error("requester ready does not match a single CDB transfer");

  // Stations empty right after a flush
  flush_quiet_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !req_valid_i[1] && !req_valid_i[2])
    else $error("station requested the CDB after a flush");

endmodule

bind expipe_top expipe_checker chk (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .flush_i    (flush_i),
  .req_valid_i(req_valid),
  .req_ready_i(req_ready),
  .cdb_ready_i(cdb_ready_i),
  .cdb_valid_i(cdb_valid_o),
  .cdb_data_i (cdb_data_o)
);

//--- tests/expipe_tb.sv
/* Self-checking testbench for expipe_top; tags are unique within one test
   Stops at the first error */
`timescale 1ns/1ps
`include "expipe_cfg.svh"

module expipe_tb
  import expipe_pkg::*;
();

  localparam int unsigned Depth = `EXPIPE_RS_DEPTH;
  localparam int unsigned NTags = 1 << `EXPIPE_ROB_IDX_LEN;
  // Requester numbering as in the top level
  localparam int ExtPort = 0;
  localparam int CsrRs   = 1;
  localparam int LinkRs  = 2;

  // ------------------------------
  // Test lengths in cycles
  // ------------------------------
  localparam int unsigned LenReset = 16;
  localparam int unsigned LenKnown = 60;
  localparam int unsigned LenExt   = 50;
  localparam int unsigned LenChain = 30;
  localparam int unsigned LenBack  = 150;
  localparam int unsigned LenFull  = 30;
  localparam int unsigned LenFlush = 40;
  localparam int unsigned TimeoutCycles =
    4 * (LenReset + LenKnown + LenExt + LenChain + LenBack + LenFull + LenFlush);

  typedef logic [`EXPIPE_XLEN-1:0] word_t;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      flush;
  logic      csr_valid;
  rs_issue_t csr_issue;
  logic      csr_ready;
  logic      link_valid;
  rs_issue_t link_issue;
  logic      link_ready;
  logic      ext_valid;
  cdb_data_t ext_data;
  logic      ext_ready;
  logic      cdb_ready;
  logic      cdb_valid;
  cdb_data_t cdb_data;

  // Reference model state per ROB tag
  logic      ref_known [NTags];
  word_t     ref_val   [NTags];
  rob_idx_t  ref_src   [NTags];
  int        owner     [NTags];
  // Results still owed in emission order per source
  rob_idx_t  csr_exp [$];
  rob_idx_t  link_exp [$];
  cdb_data_t ext_exp [$];

  string       test_name;
  int          ready_mode;  // 0 always, 1 random, 2 stalled
  int unsigned cycles = 0;
  logic        run_done;

  expipe_top UUT (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (flush),
    .csr_issue_valid_i (csr_valid),
    .csr_issue_i       (csr_issue),
    .csr_issue_ready_o (csr_ready),
    .link_issue_valid_i(link_valid),
    .link_issue_i      (link_issue),
    .link_issue_ready_o(link_ready),
    .ext_valid_i       (ext_valid),
    .ext_data_i        (ext_data),
    .ext_ready_o       (ext_ready),
    .cdb_ready_i       (cdb_ready),
    .cdb_valid_o       (cdb_valid),
    .cdb_data_o        (cdb_data)
  );

  always #50 clk_i = ~clk_i;

  // ------------------------------
  // Reporting and compares
  // ------------------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    run_done = 1'b1;
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_result(input string name, input cdb_data_t exp, input cdb_data_t act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected=%h actual=%h", name, exp, act));
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("mismatch %s expected=%b actual=%b", name, exp, act));
    end
  endtask

  // Follow the producer chain down to a known value
  function automatic word_t ref_value(input rob_idx_t tag);
    rob_idx_t t;
    word_t    v;
    logic     found;
    t     = tag;
    v     = '0;
    found = 1'b0;
    for (int i = 0; i < NTags; i++) begin
      if (!found && ref_known[t]) begin
        v     = ref_val[t];
        found = 1'b1;
      end else if (!found) begin
        t = ref_src[t];
      end
    end
    return v;
  endfunction

  task automatic clear_ref();
    for (int i = 0; i < NTags; i++) begin
      ref_known[i] = 1'b0;
      ref_val[i]   = '0;
      ref_src[i]   = '0;
      owner[i]     = -1;
    end
  endtask

  // ------------------------------
  // Scoreboard
  // ------------------------------
  always @(posedge clk_i) begin : compare_cdb
    rob_idx_t  tag;
    rob_idx_t  exp_tag;
    cdb_data_t exp;
    if (rst_ni && cdb_valid && cdb_ready) begin
      tag = cdb_data.rob_idx;
      case (owner[tag])
        ExtPort: begin
          if (ext_exp.size() == 0) begin
            report_failure($sformatf("%s: external result that was never sent", test_name));
          end else begin
            exp = ext_exp.pop_front();
            check_result({test_name, " ext"}, exp, cdb_data);
            // Only clean results satisfy operands
            if (!exp.except_raised) begin
              ref_known[tag] = 1'b1;
              ref_val[tag]   = exp.res_value;
            end
          end
        end
        CsrRs, LinkRs: begin
          if ((owner[tag] == CsrRs ? csr_exp.size() : link_exp.size()) == 0) begin
            report_failure($sformatf("%s: station emitted a result nothing waits for",
                                     test_name));
          end else begin
            exp_tag = (owner[tag] == CsrRs) ? csr_exp.pop_front() : link_exp.pop_front();
            exp.rob_idx       = exp_tag;
            exp.res_value     = ref_value(exp_tag);
            exp.except_raised = 1'b0;
            exp.except_code   = E_UNKNOWN;
            check_result({test_name, " station"}, exp, cdb_data);
          end
        end
        default: begin
          report_failure($sformatf("%s: result with tag %0d that was never issued",
                                   test_name, tag));
        end
      endcase
    end
  end

  // Watchdog
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      report_failure($sformatf("timeout after %0d cycles, results still missing", cycles));
    end
  end

  final begin
    if (!run_done) begin
      $display("Test failed");
    end
  end

  // ------------------------------
  // Drivers
  // ------------------------------
  // ROB side ready level
  always @(negedge clk_i) begin
    if (ready_mode == 0) begin
      cdb_ready = 1'b1;
    end else if (ready_mode == 1) begin
      cdb_ready = 1'($urandom_range(1, 0));
    end else begin
      cdb_ready = 1'b0;
    end
  end

  // Mode changes land between edges so the next falling edge sees them
  task automatic set_ready_mode(input int m);
    @(posedge clk_i);
    ready_mode = m;
    @(negedge clk_i);
  endtask

  task automatic issue_op(input int st, input logic known, input rob_idx_t src,
                          input word_t val, input rob_idx_t dest);
    rs_issue_t d;
    logic      taken;
    d.rs1_ready = known;
    d.rs1_idx   = src;
    d.rs1_value = val;
    d.dest_idx  = dest;
    ref_known[dest] = known;
    ref_val[dest]   = val;
    ref_src[dest]   = src;
    owner[dest]     = st;
    taken = 1'b0;
    if (st == CsrRs) begin
      csr_valid = 1'b1;
      csr_issue = d;
    end else begin
      link_valid = 1'b1;
      link_issue = d;
    end
    while (!taken) begin
      @(posedge clk_i);
      taken = (st == CsrRs) ? csr_ready : link_ready;
    end
    if (st == CsrRs) begin
      csr_exp.push_back(dest);
    end else begin
      link_exp.push_back(dest);
    end
    @(negedge clk_i);
    csr_valid  = 1'b0;
    link_valid = 1'b0;
  endtask

  task automatic ext_send(input rob_idx_t tag, input word_t val, input logic exc);
    cdb_data_t d;
    logic      taken;
    d.rob_idx       = tag;
    d.res_value     = val;
    d.except_raised = exc;
    d.except_code   = exc ? E_ILLEGAL_INSTRUCTION : E_UNKNOWN;
    owner[tag] = ExtPort;
    ext_exp.push_back(d);
    ext_valid = 1'b1;
    ext_data  = d;
    taken     = 1'b0;
    while (!taken) begin
      @(posedge clk_i);
      taken = ext_ready;
    end
    @(negedge clk_i);
    ext_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (csr_exp.size() + link_exp.size() + ext_exp.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : stimulus
    void'($urandom(22328));
    rst_ni     = 1'b0;
    flush      = 1'b0;
    csr_valid  = 1'b0;
    csr_issue  = '0;
    link_valid = 1'b0;
    link_issue = '0;
    ext_valid  = 1'b0;
    ext_data   = '0;
    cdb_ready  = 1'b0;
    ready_mode = 0;
    run_done   = 1'b0;
    test_name  = "reset";
    clear_ref();
    repeat (LenReset) @(negedge clk_i);
    check_ready("reset cdb valid", 1'b0, cdb_valid);
    check_ready("reset csr request", 1'b0, UUT.csr_valid);
    check_ready("reset link request", 1'b0, UUT.link_valid);
    check_ready("reset csr issue ready", 1'b1, csr_ready);
    check_ready("reset link issue ready", 1'b1, link_ready);
    rst_ni = 1'b1;

    // Known operands in per-station order
    test_name = "known_operands";
    set_ready_mode(0);
    for (int i = 0; i < 6; i++) begin
      issue_op(CsrRs, 1'b1, '0, word_t'($urandom), rob_idx_t'(i));
      issue_op(LinkRs, 1'b1, '0, word_t'($urandom), rob_idx_t'(i + 8));
    end
    wait_drain();

    // Capture from the external port after an ignored excepting result
    test_name = "ext_capture";
    clear_ref();
    issue_op(CsrRs, 1'b0, 4'd5, word_t'($urandom), 4'd1);
    issue_op(LinkRs, 1'b0, 4'd5, word_t'($urandom), 4'd2);
    ext_send(4'd5, word_t'($urandom), 1'b1);
    repeat (4) begin
      @(negedge clk_i);
      check_ready("ext_capture still waiting", 1'b0, cdb_valid);
    end
    ext_send(4'd5, word_t'($urandom), 1'b0);
    wait_drain();

    // Link entries chained on a CSR result
    test_name = "chained_capture";
    clear_ref();
    set_ready_mode(2);
    issue_op(LinkRs, 1'b0, 4'd3, word_t'($urandom), 4'd4);
    issue_op(LinkRs, 1'b0, 4'd4, word_t'($urandom), 4'd6);
    issue_op(CsrRs, 1'b1, '0, word_t'($urandom), 4'd3);
    set_ready_mode(0);
    wait_drain();

    // Random stalls from the ROB side
    test_name = "back_pressure";
    clear_ref();
    set_ready_mode(1);
    for (int i = 0; i < 10; i++) begin
      issue_op(1 + int'($urandom_range(1, 0)), 1'b1, '0, word_t'($urandom), rob_idx_t'(i));
    end
    // Producers 14 and 15 are sent only after every waiter is in
    issue_op(CsrRs, 1'b0, 4'd14, word_t'($urandom), 4'd10);
    issue_op(LinkRs, 1'b0, 4'd15, word_t'($urandom), 4'd11);
    issue_op(LinkRs, 1'b0, 4'd10, word_t'($urandom), 4'd12);
    ext_send(4'd14, word_t'($urandom), 1'b0);
    ext_send(4'd15, word_t'($urandom), 1'b0);
    wait_drain();

    // Fill the CSR station under a stall
    test_name = "full_station";
    clear_ref();
    set_ready_mode(2);
    for (int i = 0; i < Depth; i++) begin
      issue_op(CsrRs, 1'b1, '0, word_t'($urandom), rob_idx_t'(i));
    end
    check_ready("full_station csr issue ready", 1'b0, csr_ready);
    check_ready("full_station link issue ready", 1'b1, link_ready);
    set_ready_mode(0);
    @(posedge clk_i);
    while (!(cdb_valid && cdb_ready)) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    check_ready("full_station ready after pop", 1'b1, csr_ready);
    wait_drain();

    // Flush drops everything in both stations
    test_name = "flush";
    clear_ref();
    set_ready_mode(2);
    issue_op(CsrRs, 1'b1, '0, word_t'($urandom), 4'd0);
    issue_op(CsrRs, 1'b0, 4'd9, word_t'($urandom), 4'd1);
    issue_op(LinkRs, 1'b1, '0, word_t'($urandom), 4'd2);
    issue_op(LinkRs, 1'b0, 4'd1, word_t'($urandom), 4'd3);
    flush = 1'b1;
    @(negedge clk_i);
    flush = 1'b0;
    csr_exp.delete();
    link_exp.delete();
    set_ready_mode(0);
    repeat (4) begin
      @(negedge clk_i);
      check_ready("flush no result", 1'b0, cdb_valid);
    end
    check_ready("flush csr issue ready", 1'b1, csr_ready);
    check_ready("flush link issue ready", 1'b1, link_ready);
    clear_ref();
    issue_op(CsrRs, 1'b1, '0, word_t'($urandom), 4'd5);
    issue_op(LinkRs, 1'b1, '0, word_t'($urandom), 4'd6);
    wait_drain();

    run_done = 1'b1;
    $display("Test passed");
    $finish;
  end

endmodule

//--- files.f
+incdir+logic
logic/expipe_pkg.sv
logic/modn_counter.sv
logic/op_only_rs.sv
logic/cdb_arbiter.sv
logic/expipe_top.sv
tests/expipe_checker.sv
tests/expipe_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := expipe_tb
FILELIST := files.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := Test passed

SRCS := $(shell grep -v '^+' $(FILELIST)) logic/expipe_cfg.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
